// ==== tb/nts_dispatcher_testdata.txt ====
# I = idle and identity check, D = wait, read out, discard
# F len lastmask good | W addr data | R addr expected, all hex but len and good
I
R 010 00000000
R 011 00000000
R 003 00000000
# Single good frame
F 5 ff 1
D
# Bad frame is dropped, next good frame intact
F 4 ff 0
F 3 0f 1
D
# Back to back frames using both buffers
F 6 01 1
F 4 80 1
D
D
# Five starts of frame so far
R 010 00000000
R 011 00000005
# Scratch register
W 003 a5a55a5a
R 003 a5a55a5a
W 003 12345678
R 003 12345678
R 002 302e3031
# Overrun keeps only the first 256 words
F 300 3f 1
D
R 010 00000000
R 011 00000006
R 003 12345678
# Short frame after overrun
F 2 ff 1
D
R 010 00000000
R 011 00000007
# Another pair back to back
F 7 c0 1
F 3 ff 0
F 2 1f 1
D
D
R 010 00000000
R 011 0000000a
I

// ==== nts_dispatcher.f ====
hw/nts_rx_pkg.sv
hw/nts_api_pkg.sv
hw/nts_bram.sv
hw/nts_sof_counter.sv
hw/nts_buffer_fsm.sv
hw/nts_api_regs.sv
hw/nts_dispatcher.sv
tb/nts_dispatch_checker.sv
tb/tb_nts_dispatcher.sv

// ==== run_nts_dispatcher.sh ====
#!/usr/bin/env bash
# Build and run the dispatcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f nts_dispatcher.f --top-module tb_nts_dispatcher -o sim_nts \
  && ./obj_dir/sim_nts | tee /dev/stderr | grep -x "TB PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb/tb_nts_dispatcher.sv ====
`timescale 1ns/1ns
`default_nettype none
//----------------------------------------
// Dispatcher testbench
// Runs commands from the testdata file
// against the DUT and prints a summary
//----------------------------------------

module tb_nts_dispatcher
  import nts_rx_pkg::*, nts_api_pkg::*;
();

  localparam int ADDR_WIDTH = 8;
  localparam int DEPTH      = 2 ** ADDR_WIDTH;

  logic                  clk;
  logic                  areset;
  mac_rx_t               rx;
  logic                  rd_start;
  logic                  read_discard;
  api_req_t              api;
  logic                  packet_available;
  logic [ADDR_WIDTH-1:0] dispatch_counter;
  logic [MASK_WIDTH-1:0] dispatch_data_valid;
  logic                  fifo_empty;
  fifo_rd_t              fifo_rd;
  logic [31:0]           api_read_data;
  int                    errors;
  // Command lines, timeout state and data generator
  string                 lines [$];
  int                    cycle_count;
  int                    cycle_limit;
  logic [63:0]           rng_state;
  logic                  loaded;

  nts_dispatcher #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) dut (
    .i_clk                 (clk),
    .i_areset              (areset),
    .i_rx                  (rx),
    .o_packet_available    (packet_available),
    .o_dispatch_counter    (dispatch_counter),
    .o_dispatch_data_valid (dispatch_data_valid),
    .o_fifo_empty          (fifo_empty),
    .o_fifo_rd             (fifo_rd),
    .i_rd_start            (rd_start),
    .i_read_discard        (read_discard),
    .i_api                 (api),
    .o_api_read_data       (api_read_data)
  );

  nts_dispatch_checker #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) chk (
    .i_clk                 (clk),
    .i_areset              (areset),
    .i_packet_available    (packet_available),
    .i_dispatch_counter    (dispatch_counter),
    .i_dispatch_data_valid (dispatch_data_valid),
    .i_fifo_empty          (fifo_empty),
    .i_fifo_rd             (fifo_rd),
    .i_api                 (api),
    .i_api_read_data       (api_read_data),
    .o_errors              (errors)
  );

  // 40 ns clock
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, DUT stopped responding", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  //----------------------------------------
  // Stimulus tasks driven on the falling edge
  //----------------------------------------
  task automatic send_frame(input int len, input logic [7:0] last_mask, input logic good);
    int i;
    // Idle beat first so the full beat counts as a start
    @(negedge clk);
    rx = '0;
    if (good)
      chk.add_frame((len < DEPTH) ? len : DEPTH, last_mask);
    for (i = 0; i < len; i++) begin
      @(negedge clk);
      rng_state     = xorshift64(rng_state);
      rx.data       = rng_state;
      rx.data_valid = (i == len - 1) ? last_mask : 8'hff;
      rx.good_frame = good && (i == len - 1);
      rx.bad_frame  = !good && (i == len - 1);
      // Words past the buffer depth are dropped
      if (good && i < DEPTH)
        chk.add_word(rng_state);
    end
    @(negedge clk);
    rx = '0;
  endtask

  task automatic read_out();
    int wait_cycles;
    wait_cycles = 0;
    @(negedge clk);
    while (!packet_available && wait_cycles < 64) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!packet_available) begin
      chk.report_failure("o_packet_available never rose for a pending frame");
    end else begin
      rd_start = 1'b1;
      @(negedge clk);
      rd_start    = 1'b0;
      wait_cycles = 0;
      while (!fifo_rd.valid && wait_cycles < 16) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (!fifo_rd.valid)
        chk.report_failure("no read-out stream after rd_start");
      wait_cycles = 0;
      while (fifo_rd.valid && wait_cycles < DEPTH + 16) begin
        @(negedge clk);
        wait_cycles++;
      end
      read_discard = 1'b1;
      @(negedge clk);
      read_discard = 1'b0;
    end
  endtask

  task automatic api_write(input logic [11:0] addr, input logic [31:0] data);
    @(negedge clk);
    api.cs         = 1'b1;
    api.we         = 1'b1;
    api.addr       = addr;
    api.write_data = data;
    @(negedge clk);
    api = '0;
  endtask

  task automatic api_read(input logic [11:0] addr, input logic [31:0] expected);
    chk.add_api_read(expected);
    @(negedge clk);
    api.cs         = 1'b1;
    api.we         = 1'b0;
    api.addr       = addr;
    api.write_data = '0;
    @(negedge clk);
    api = '0;
  endtask

  task automatic identity_check();
    chk.expect_idle();
    api_read(ADDR_NAME0, CORE_NAME[63:32]);
    api_read(ADDR_NAME1, CORE_NAME[31:0]);
    api_read(ADDR_VERSION, CORE_VERSION);
  endtask

  //----------------------------------------
  // Command file
  //----------------------------------------
  task automatic load_commands(output logic ok);
    int    fd;
    int    frame_words;
    int    len;
    string line;
    frame_words = 0;
    fd = $fopen("tb/nts_dispatcher_testdata.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 1 && line.getc(0) != "#") begin
          lines.push_back(line);
          if (line.getc(0) == "F" && $sscanf(line.substr(1, line.len() - 1), "%d", len) == 1)
            frame_words += len;
        end
      end
      $fclose(fd);
      // Total frame words plus slack for every command
      cycle_limit = frame_words + 20 * lines.size();
    end
  endtask

  task automatic run_command(input string line);
    logic [7:0]  cmd;
    string       args;
    int          len;
    int          good;
    logic [7:0]  mask;
    logic [11:0] addr;
    logic [31:0] data;
    cmd  = line.getc(0);
    args = line.substr(1, line.len() - 1);
    case (cmd)
      "I": identity_check();
      "D": read_out();
      "F": begin
        void'($sscanf(args, "%d %h %d", len, mask, good));
        send_frame(len, mask, good != 0);
      end
      "W": begin
        void'($sscanf(args, "%h %h", addr, data));
        api_write(addr, data);
      end
      "R": begin
        void'($sscanf(args, "%h %h", addr, data));
        api_read(addr, data);
      end
      default: chk.report_failure($sformatf("unknown command line: %s", line));
    endcase
  endtask

  initial begin
    rx           = '0;
    rd_start     = 1'b0;
    read_discard = 1'b0;
    api          = '0;
    areset       = 1'b1;
    cycle_count  = 0;
    cycle_limit  = 0;
    rng_state    = 64'd52462;
    load_commands(loaded);
    if (!loaded) begin
      $display("could not open the testdata file");
      $display("TB FAILED");
      $finish;
    end else begin
      repeat (8) @(posedge clk);
      @(negedge clk);
      areset = 1'b0;
      foreach (lines[i]) begin
        run_command(lines[i]);
      end
      repeat (4) @(negedge clk);
      chk.finish_check();
      $display("errors: %0d", errors);
      if (errors == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb/nts_dispatch_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
//----------------------------------------
// Dispatcher checker
// Compares read-out stream, frame info
// and API reads with expected values
//----------------------------------------

module nts_dispatch_checker
  import nts_rx_pkg::*;
  import nts_api_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                   i_clk,
  input  wire                   i_areset,
  input  wire                   i_packet_available,
  input  wire  [ADDR_WIDTH-1:0] i_dispatch_counter,
  input  wire  [MASK_WIDTH-1:0] i_dispatch_data_valid,
  input  wire                   i_fifo_empty,
  input  wire fifo_rd_t         i_fifo_rd,
  input  wire api_req_t         i_api,
  input  wire  [31:0]           i_api_read_data,
  output int                    o_errors
);

  // Expected frames, words and API reads, oldest first
  int                    exp_len [$];
  logic [MASK_WIDTH-1:0] exp_mask [$];
  logic [WORD_WIDTH-1:0] exp_words [$];
  logic [31:0]           exp_api [$];
  int                    beats;
  logic                  in_stream;
  logic                  offer_seen;
  logic                  idle_pending;
  logic [WORD_WIDTH-1:0] exp_word;

  initial begin
    o_errors     = 0;
    beats        = 0;
    in_stream    = 1'b0;
    offer_seen   = 1'b0;
    idle_pending = 1'b0;
  end

  //----------------------------------------
  // Calls from the testbench top
  //----------------------------------------
  task automatic add_frame(input int len, input logic [MASK_WIDTH-1:0] mask);
    exp_len.push_back(len);
    exp_mask.push_back(mask);
  endtask

  task automatic add_word(input logic [WORD_WIDTH-1:0] word);
    exp_words.push_back(word);
  endtask

  task automatic add_api_read(input logic [31:0] value);
    exp_api.push_back(value);
  endtask

  task automatic expect_idle();
    idle_pending = 1'b1;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    o_errors = o_errors + 1;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
    o_errors = o_errors + 1;
  endtask

  // Leftovers mean frames that never came out
  task automatic finish_check();
    if (exp_len.size() != 0) begin
      report_failure($sformatf("%0d good frames were never read out", exp_len.size()));
    end
    if (exp_api.size() != 0) begin
      report_failure("API reads were expected but never seen");
    end
  endtask

  //----------------------------------------
  // Port monitor
  //----------------------------------------
  always @(posedge i_clk) begin
    if (!i_areset) begin
      // Quiet engine side after reset
      if (idle_pending) begin
        idle_pending = 1'b0;
        if (i_fifo_empty !== 1'b1)
          report_mismatch("o_fifo_empty", 64'd1, 64'(i_fifo_empty));
        if (i_packet_available !== 1'b0)
          report_mismatch("o_packet_available", 64'd0, 64'(i_packet_available));
        if (i_fifo_rd.valid !== 1'b0)
          report_mismatch("o_fifo_rd.valid", 64'd0, 64'(i_fifo_rd.valid));
      end

      // Frame info checked once per offer
      if (i_packet_available && !offer_seen) begin
        offer_seen = 1'b1;
        if (exp_len.size() == 0) begin
          report_failure("packet offered with no good frame pending");
        end else begin
          if (i_dispatch_counter !== ADDR_WIDTH'(exp_len[0] - 1))
            report_mismatch("o_dispatch_counter", 64'(exp_len[0] - 1),
                            64'(i_dispatch_counter));
          if (i_dispatch_data_valid !== exp_mask[0])
            report_mismatch("o_dispatch_data_valid", 64'(exp_mask[0]),
                            64'(i_dispatch_data_valid));
        end
      end

      // Read-out words
      if (i_fifo_rd.valid) begin
        in_stream = 1'b1;
        beats     = beats + 1;
        if (exp_words.size() == 0) begin
          report_failure("read-out word with no word expected");
        end else begin
          exp_word = exp_words.pop_front();
          if (i_fifo_rd.data !== exp_word)
            report_mismatch("o_fifo_rd.data", exp_word, i_fifo_rd.data);
        end
      end else if (in_stream) begin
        // End of stream
        in_stream = 1'b0;
        if (exp_len.size() == 0) begin
          report_failure("read-out stream with no frame expected");
        end else begin
          if (beats != exp_len[0])
            report_failure($sformatf("stream gave %0d words, expected %0d",
                                     beats, exp_len[0]));
          // Realign with the next frame
          while (beats < exp_len[0] && exp_words.size() != 0) begin
            exp_word = exp_words.pop_front();
            beats    = beats + 1;
          end
          void'(exp_len.pop_front());
          void'(exp_mask.pop_front());
        end
        beats      = 0;
        offer_seen = 1'b0;
      end

      // API reads are combinational
      if (i_api.cs && !i_api.we) begin
        if (exp_api.size() == 0) begin
          report_failure("API read with no expected value");
        end else if (i_api_read_data !== exp_api[0]) begin
          report_mismatch("o_api_read_data", 64'(exp_api[0]), 64'(i_api_read_data));
          void'(exp_api.pop_front());
        end else begin
          void'(exp_api.pop_front());
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/nts_dispatcher.sv ====
`timescale 1ns/1ns
`default_nettype none
//----------------------------------------
// NTS receive dispatcher top level
// MAC frames into two RAM buffers, handed
// to the engine one at a time
//----------------------------------------

module nts_dispatcher
  import nts_rx_pkg::*;
  import nts_api_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                    i_clk,
  input  wire                    i_areset,
  // MAC receive
  input  wire mac_rx_t           i_rx,
  // Engine side
  output wire                    o_packet_available,
  output wire [ADDR_WIDTH-1:0]   o_dispatch_counter,
  output wire [MASK_WIDTH-1:0]   o_dispatch_data_valid,
  output wire                    o_fifo_empty,
  output fifo_rd_t               o_fifo_rd,
  input  wire                    i_rd_start,
  input  wire                    i_read_discard,
  // Register access
  input  wire api_req_t          i_api,
  output wire [31:0]             o_api_read_data
);

  logic                  sof;
  logic                  latch_lsb;
  frame_count_u          frame_count;
  logic [31:0]           frame_count_lsb;
  // RAM port wires, index per buffer
  logic [ADDR_WIDTH-1:0] ram_addr  [2];
  logic                  ram_we    [2];
  logic [WORD_WIDTH-1:0] ram_wdata [2];
  logic [WORD_WIDTH-1:0] ram_rdata [2];

  //----------------------------------------
  // Frame start and counter
  //----------------------------------------
  nts_sof_counter sof_counter (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_rx_data_valid (i_rx.data_valid),
    .i_latch_lsb     (latch_lsb),
    .o_sof           (sof),
    .o_count         (frame_count),
    .o_count_lsb     (frame_count_lsb)
  );

  //----------------------------------------
  // Buffer control and RAMs
  //----------------------------------------
  nts_buffer_fsm #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) buffer_fsm (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_rx                  (i_rx),
    .i_sof                 (sof),
    .i_rd_start            (i_rd_start),
    .i_read_discard        (i_read_discard),
    .i_ram_rdata0          (ram_rdata[0]),
    .i_ram_rdata1          (ram_rdata[1]),
    .o_ram_addr0           (ram_addr[0]),
    .o_ram_addr1           (ram_addr[1]),
    .o_ram_we0             (ram_we[0]),
    .o_ram_we1             (ram_we[1]),
    .o_ram_wdata0          (ram_wdata[0]),
    .o_ram_wdata1          (ram_wdata[1]),
    .o_packet_available    (o_packet_available),
    .o_dispatch_counter    (o_dispatch_counter),
    .o_dispatch_data_valid (o_dispatch_data_valid),
    .o_fifo_empty          (o_fifo_empty),
    .o_fifo_rd             (o_fifo_rd)
  );

  nts_bram #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (WORD_WIDTH)
  ) mem0 (
    .i_clk   (i_clk),
    .i_addr  (ram_addr[0]),
    .i_write (ram_we[0]),
    .i_data  (ram_wdata[0]),
    .o_data  (ram_rdata[0])
  );

  nts_bram #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (WORD_WIDTH)
  ) mem1 (
    .i_clk   (i_clk),
    .i_addr  (ram_addr[1]),
    .i_write (ram_we[1]),
    .i_data  (ram_wdata[1]),
    .o_data  (ram_rdata[1])
  );

  //----------------------------------------
  // Register block
  //----------------------------------------
  nts_api_regs api_regs (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_api           (i_api),
    .i_count         (frame_count),
    .i_count_lsb     (frame_count_lsb),
    .o_latch_lsb     (latch_lsb),
    .o_api_read_data (o_api_read_data)
  );

endmodule

`default_nettype wire

// ==== hw/nts_api_regs.sv ====
`timescale 1ns/1ns
`default_nettype none
//----------------------------------------
// Dispatcher register block
// Identity, scratch register and frame
// counter read-back, reads are combinational
//----------------------------------------

module nts_api_regs
  import nts_api_pkg::*;
(
  input  wire                i_clk,
  input  wire                i_areset,
  input  wire api_req_t      i_api,
  input  wire frame_count_u  i_count,
  input  wire  [31:0]        i_count_lsb,
  output logic               o_latch_lsb,
  output logic [31:0]        o_api_read_data
);

  logic        rd_en;
  logic        wr_en;
  logic [31:0] dummy_q;

  assign rd_en = i_api.cs && !i_api.we;
  assign wr_en = i_api.cs && i_api.we;

  // High half read snapshots the low half
  assign o_latch_lsb = rd_en && (i_api.addr == ADDR_FRAMES_MSB);

  //----------------------------------------
  // Scratch register
  //----------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      dummy_q <= '0;
    end else if (wr_en && (i_api.addr == ADDR_DUMMY)) begin
      dummy_q <= i_api.write_data;
    end
  end

  //----------------------------------------
  // Read mux
  //----------------------------------------
  always_comb begin
    o_api_read_data = '0;
    if (rd_en) begin
      case (i_api.addr)
        ADDR_NAME0:      o_api_read_data = CORE_NAME[63:32];
        ADDR_NAME1:      o_api_read_data = CORE_NAME[31:0];
        ADDR_VERSION:    o_api_read_data = CORE_VERSION;
        ADDR_DUMMY:      o_api_read_data = dummy_q;
        ADDR_FRAMES_MSB: o_api_read_data = i_count.half.msb;
        // Value held since the last high half read
        ADDR_FRAMES_LSB: o_api_read_data = i_count_lsb;
        default:         o_api_read_data = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/nts_buffer_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none
//----------------------------------------
// Double buffer control for the dispatcher
// Writes MAC frames into one RAM while the
// other is streamed out to the engine
//----------------------------------------

module nts_buffer_fsm
  import nts_rx_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                    i_clk,
  input  wire                    i_areset,
  input  wire mac_rx_t           i_rx,
  input  wire                    i_sof,
  input  wire                    i_rd_start,
  input  wire                    i_read_discard,
  input  wire  [WORD_WIDTH-1:0]  i_ram_rdata0,
  input  wire  [WORD_WIDTH-1:0]  i_ram_rdata1,
  output logic [ADDR_WIDTH-1:0]  o_ram_addr0,
  output logic [ADDR_WIDTH-1:0]  o_ram_addr1,
  output logic                   o_ram_we0,
  output logic                   o_ram_we1,
  output logic [WORD_WIDTH-1:0]  o_ram_wdata0,
  output logic [WORD_WIDTH-1:0]  o_ram_wdata1,
  output logic                   o_packet_available,
  output logic [ADDR_WIDTH-1:0]  o_dispatch_counter,
  output logic [MASK_WIDTH-1:0]  o_dispatch_data_valid,
  output logic                   o_fifo_empty,
  output fifo_rd_t               o_fifo_rd
);

  // Per-buffer state, last word index and final mask
  buf_state_e            state_q [2];
  logic [ADDR_WIDTH-1:0] count_q [2];
  logic [MASK_WIDTH-1:0] mask_q  [2];
  // cur_q is the write buffer, rd_sel the read buffer
  logic                  cur_q;
  logic                  rd_sel;
  // RAM write port registers
  logic [1:0]            we_q;
  logic [ADDR_WIDTH-1:0] waddr_q [2];
  logic [WORD_WIDTH-1:0] wdata_q;
  // Shared read address and output stage
  logic [ADDR_WIDTH-1:0] raddr_q;
  logic                  fifo_empty_q;
  logic                  rd_load;
  logic                  rd_valid_q;
  logic [WORD_WIDTH-1:0] rd_data_q;
  logic [WORD_WIDTH-1:0] rd_word;

  assign rd_sel  = ~cur_q;
  assign rd_word = rd_sel ? i_ram_rdata1 : i_ram_rdata0;

  // Output stage loads RAM data in these two states
  assign rd_load = !i_read_discard &&
                   (state_q[rd_sel] == fifo_out || state_q[rd_sel] == out_fin0);

  //----------------------------------------
  // Buffer state machines
  //----------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q[0]   <= empty;
      state_q[1]   <= empty;
      count_q[0]   <= '0;
      count_q[1]   <= '0;
      mask_q[0]    <= '0;
      mask_q[1]    <= '0;
      waddr_q[0]   <= '0;
      waddr_q[1]   <= '0;
      we_q         <= '0;
      cur_q        <= 1'b0;
      raddr_q      <= '0;
      fifo_empty_q <= 1'b1;
      rd_valid_q   <= 1'b0;
    end else begin
      we_q       <= '0;
      rd_valid_q <= rd_load;

      // Read side, engine may drop the buffer at any point
      if (i_read_discard) begin
        state_q[rd_sel] <= empty;
        fifo_empty_q    <= 1'b1;
      end else begin
        case (state_q[rd_sel])
          out_init0: begin
            // Prime RAM with word 0 while waiting
            if (i_rd_start) begin
              state_q[rd_sel] <= out_init1;
            end
            raddr_q      <= '0;
            fifo_empty_q <= 1'b0;
          end
          out_init1: begin
            raddr_q <= ADDR_WIDTH'(1);
            // Single word frame skips the streaming loop
            if (count_q[rd_sel] == '0) begin
              state_q[rd_sel] <= out_fin0;
            end else begin
              state_q[rd_sel] <= fifo_out;
            end
          end
          fifo_out: begin
            if (raddr_q == count_q[rd_sel]) begin
              state_q[rd_sel] <= out_fin0;
            end else begin
              raddr_q <= raddr_q + 1'b1;
            end
          end
          out_fin0: state_q[rd_sel] <= out_fin1;
          // Parked until the engine discards
          out_fin1: fifo_empty_q <= 1'b1;
          default: ;
        endcase
      end

      // Write side
      if (i_rx.bad_frame) begin
        state_q[cur_q] <= empty;
        waddr_q[cur_q] <= '0;
        count_q[cur_q] <= '0;
        mask_q[cur_q]  <= '0;
      end else begin
        case (state_q[cur_q])
          empty: begin
            if (i_sof) begin
              state_q[cur_q] <= has_data;
            end
          end
          has_data: begin
            if (i_rx.good_frame) begin
              mask_q[cur_q]  <= i_rx.data_valid;
              state_q[cur_q] <= packet_received;
            end
          end
          packet_received: begin
            // Hand over once the engine buffer is free
            if (state_q[rd_sel] == empty) begin
              state_q[cur_q] <= out_init0;
              cur_q          <= rd_sel;
            end
          end
          default: state_q[cur_q] <= empty;
        endcase

        // Store each beat carrying data, saturate on overrun
        if (i_rx.data_valid != '0) begin
          case (state_q[cur_q])
            empty: begin
              we_q[cur_q]    <= 1'b1;
              waddr_q[cur_q] <= '0;
              count_q[cur_q] <= '0;
            end
            has_data: begin
              if (count_q[cur_q] != '1) begin
                we_q[cur_q]    <= 1'b1;
                waddr_q[cur_q] <= count_q[cur_q] + 1'b1;
                count_q[cur_q] <= count_q[cur_q] + 1'b1;
              end
            end
            default: ;
          endcase
        end
      end
    end
  end

  // Data path registers
  always_ff @(posedge i_clk) begin
    if (i_rx.data_valid != '0) begin
      wdata_q <= i_rx.data;
    end
    if (rd_load) begin
      rd_data_q <= rd_word;
    end
  end

  //----------------------------------------
  // RAM ports and engine outputs
  //----------------------------------------
  assign o_ram_addr0  = we_q[0] ? waddr_q[0] : raddr_q;
  assign o_ram_addr1  = we_q[1] ? waddr_q[1] : raddr_q;
  assign o_ram_we0    = we_q[0];
  assign o_ram_we1    = we_q[1];
  assign o_ram_wdata0 = wdata_q;
  assign o_ram_wdata1 = wdata_q;

  assign o_packet_available    = (state_q[rd_sel] == out_init0);
  assign o_dispatch_counter    = count_q[rd_sel];
  assign o_dispatch_data_valid = mask_q[rd_sel];
  assign o_fifo_empty          = fifo_empty_q;
  assign o_fifo_rd.valid       = rd_valid_q;
  assign o_fifo_rd.data        = rd_data_q;

endmodule

`default_nettype wire

// ==== hw/nts_sof_counter.sv ====
`timescale 1ns/1ns
`default_nettype none
//----------------------------------------
// Start-of-frame detector and counter
// Counts zero-to-full mask transitions
// and holds a low half for the API
//----------------------------------------

module nts_sof_counter
  import nts_api_pkg::*;
(
  input  wire                i_clk,
  input  wire                i_areset,
  input  wire  [7:0]         i_rx_data_valid,
  input  wire                i_latch_lsb,
  output logic               o_sof,
  output frame_count_u       o_count,
  output logic [31:0]        o_count_lsb
);

  // Reset to full so that no start is seen on the first beat
  logic [7:0]   prev_valid_q;
  frame_count_u count_q;
  logic [31:0]  lsb_q;

  // Idle beat then a full beat
  assign o_sof = (prev_valid_q == 8'h00) && (i_rx_data_valid == 8'hff);

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      prev_valid_q  <= 8'hff;
      count_q.count <= '0;
      lsb_q         <= '0;
    end else begin
      prev_valid_q <= i_rx_data_valid;
      if (o_sof) begin
        count_q.count <= count_q.count + 64'd1;
      end
      // Freeze low half when the high half is read
      if (i_latch_lsb) begin
        lsb_q <= count_q.half.lsb;
      end
    end
  end

  assign o_count     = count_q;
  assign o_count_lsb = lsb_q;

endmodule

`default_nettype wire

// ==== hw/nts_bram.sv ====
`timescale 1ns/1ns
`default_nettype none
//----------------------------------------
// Single-port block RAM
// Synchronous write, registered read
//----------------------------------------

module nts_bram #(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 64
) (
  input  wire                   i_clk,
  input  wire  [ADDR_WIDTH-1:0] i_addr,
  input  wire                   i_write,
  input  wire  [DATA_WIDTH-1:0] i_data,
  output logic [DATA_WIDTH-1:0] o_data
);

  // Storage, one frame deep
  logic [DATA_WIDTH-1:0] mem [0:(2**ADDR_WIDTH)-1];

  // Read returns the old word on a write cycle
  always_ff @(posedge i_clk) begin
    if (i_write) begin
      mem[i_addr] <= i_data;
    end
    o_data <= mem[i_addr];
  end

endmodule

`default_nettype wire

// ==== hw/nts_api_pkg.sv ====
`default_nettype none
//----------------------------------------
// NTS dispatcher register interface
// Address map, identity constants, the
// request bundle and counter snapshot
//----------------------------------------

package nts_api_pkg;

  // Address map
  localparam logic [11:0] ADDR_NAME0      = 12'h000;
  localparam logic [11:0] ADDR_NAME1      = 12'h001;
  localparam logic [11:0] ADDR_VERSION    = 12'h002;
  localparam logic [11:0] ADDR_DUMMY      = 12'h003;
  localparam logic [11:0] ADDR_FRAMES_MSB = 12'h010;
  localparam logic [11:0] ADDR_FRAMES_LSB = 12'h011;

  // "NTS_DSPT" and "0.01" in ASCII
  localparam logic [63:0] CORE_NAME    = 64'h4e54_535f_4453_5054;
  localparam logic [31:0] CORE_VERSION = 32'h302e_3031;

  // One register access, read when we is low
  typedef struct packed {
    logic        cs;
    logic        we;
    logic [11:0] addr;
    logic [31:0] write_data;
  } api_req_t;

  // Frame counter, seen as one count or as two API words
  typedef union packed {
    logic [63:0] count;
    struct packed {
      logic [31:0] msb;
      logic [31:0] lsb;
    } half;
  } frame_count_u;

endpackage

`default_nettype wire

// ==== hw/nts_rx_pkg.sv ====
`default_nettype none
//----------------------------------------
// NTS receive dispatcher types
// MAC receive beats, per-buffer state and
// the engine side read-out stream
//----------------------------------------

package nts_rx_pkg;

  // Width of one MAC word and its byte mask
  localparam int WORD_WIDTH = 64;
  localparam int MASK_WIDTH = 8;

  // One MAC receive beat
  typedef struct packed {
    logic [MASK_WIDTH-1:0] data_valid;
    logic [WORD_WIDTH-1:0] data;
    logic                  bad_frame;
    logic                  good_frame;
  } mac_rx_t;

  // Life cycle of one frame buffer
  // Write side uses the first three, read side the rest
  typedef enum logic [3:0] {
    empty           = 4'd0,
    has_data        = 4'd1,
    packet_received = 4'd2,
    out_init0       = 4'd3,
    out_init1       = 4'd4,
    fifo_out        = 4'd5,
    out_fin0        = 4'd6,
    out_fin1        = 4'd7
  } buf_state_e;

  // One read-out beat towards the engine
  typedef struct packed {
    logic                  valid;
    logic [WORD_WIDTH-1:0] data;
  } fifo_rd_t;

endpackage

`default_nettype wire
